// ==== flist.f ====
gpu_issue_pkg.sv
instr_buffer.sv
scoreboard_warp.sv
scoreboard.sv
issue_unit.sv
exec_pipe.sv
issue_top.sv
tb_clock.sv
issue_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= issue_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== issue_tb.sv ====
`timescale 1ns/1ns

module issue_tb;

    localparam int NUM_WARPS    = gpu_issue_pkg::NUM_WARPS;
    localparam int EXEC_LATENCY = gpu_issue_pkg::EXEC_LATENCY;
    localparam int MAX_PENDING  = gpu_issue_pkg::IB_DEPTH + gpu_issue_pkg::NUM_SLOTS;
    localparam int RAND_INSTRS  = 1400;
    localparam int SEND_LIMIT   = 200;   // Cycles an offer may wait for in_ready
    localparam int DRAIN_LIMIT  = 1000;
    localparam gpu_issue_pkg::warp_id_t BURST_WARP = 3'd5;

    typedef struct packed {
        gpu_issue_pkg::reg_id_t src1;
        gpu_issue_pkg::reg_id_t src2;
        gpu_issue_pkg::reg_id_t dst;
        logic                   src1_valid;
        logic                   src2_valid;
        logic                   dst_valid;
    } instr_t;

    typedef struct packed {
        gpu_issue_pkg::warp_id_t warp;
        instr_t                  ins;
        int                      stamp;  // Cycle of acceptance or writeback
    } entry_t;

    logic                    clk, rst;
    logic                    in_valid, in_ready;
    gpu_issue_pkg::warp_id_t in_warp;
    gpu_issue_pkg::reg_id_t  in_src1, in_src2, in_dst;
    logic                    in_src1_valid, in_src2_valid, in_dst_valid;
    logic                    wb_valid, wb_dst_valid;
    gpu_issue_pkg::warp_id_t wb_warp;
    gpu_issue_pkg::reg_id_t  wb_dst;

    // Reference model state
    entry_t acc_q  [$];                  // Accepted, not yet written back
    entry_t hist_q [$];                  // Writebacks of the last EXEC_LATENCY cycles
    int     outstanding [NUM_WARPS];
    int     cycle, run, max_run, checks, errors;
    bit     timed_out, burst_active, ready_fell, ready_rose;

    tb_clock #(.PERIOD(100)) tb_clock_inst (.clk(clk));

    issue_top #(
        .NUM_WARPS    (NUM_WARPS),
        .EXEC_LATENCY (EXEC_LATENCY)
    ) issue_top_inst (
        .clk, .rst, .in_valid, .in_ready, .in_warp, .in_src1, .in_src2, .in_dst,
        .in_src1_valid, .in_src2_valid, .in_dst_valid,
        .wb_valid, .wb_warp, .wb_dst, .wb_dst_valid
    );

    ////////////////////////////////////////////////////////////////////////////
    // Model helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_that(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("[FAIL] %0t ns: %s", $time, msg);
        end
    endtask

    function automatic instr_t make_instr(input gpu_issue_pkg::reg_id_t s1, input logic s1v,
                                          input gpu_issue_pkg::reg_id_t s2, input logic s2v,
                                          input gpu_issue_pkg::reg_id_t d, input logic dv);
        instr_t ins;
        ins.src1       = s1;
        ins.src2       = s2;
        ins.dst        = d;
        ins.src1_valid = s1v;
        ins.src2_valid = s2v;
        ins.dst_valid  = dv;
        return ins;
    endfunction

    // Later instruction reads, rewrites or overwrites what the earlier one uses
    function automatic bit hazard(input instr_t later, input instr_t earlier);
        bit raw, waw, war;
        raw = earlier.dst_valid &&
              ((later.src1_valid && later.src1 == earlier.dst) ||
               (later.src2_valid && later.src2 == earlier.dst));
        waw = later.dst_valid && earlier.dst_valid && later.dst == earlier.dst;
        war = later.dst_valid &&
              ((earlier.src1_valid && earlier.src1 == later.dst) ||
               (earlier.src2_valid && earlier.src2 == later.dst));
        return raw || waw || war;
    endfunction

    task automatic accept();
        entry_t e;
        e.warp  = in_warp;
        e.ins   = make_instr(in_src1, in_src1_valid, in_src2, in_src2_valid,
                             in_dst, in_dst_valid);
        e.stamp = cycle;
        acc_q.push_back(e);
        outstanding[in_warp]++;
        check_that(outstanding[in_warp] <= MAX_PENDING,
                   $sformatf("warp %0d has %0d instructions pending", in_warp,
                             outstanding[in_warp]));
    endtask

    task automatic retire(input gpu_issue_pkg::warp_id_t w, input gpu_issue_pkg::reg_id_t d,
                          input logic dv);
        int     idx;
        int     in_window;
        entry_t e;
        idx       = -1;
        in_window = 1;                                 // This writeback itself
        foreach (acc_q[i])
            if (idx < 0 && acc_q[i].warp == w)
                idx = i;                               // Oldest of this warp
        check_that(idx >= 0, $sformatf("writeback on warp %0d with nothing pending", w));
        if (idx >= 0) begin
            e = acc_q[idx];
            acc_q.delete(idx);
            outstanding[w]--;
            check_that(e.ins.dst == d && e.ins.dst_valid == dv,
                       $sformatf("warp %0d wrote back dst %0d/%0b, expected %0d/%0b",
                                 w, d, dv, e.ins.dst, e.ins.dst_valid));
            foreach (hist_q[i]) begin
                if (hist_q[i].warp == w) begin
                    in_window++;
                    check_that(!hazard(e.ins, hist_q[i].ins),
                               $sformatf("warp %0d dependent writeback %0d cycles apart",
                                         w, cycle - hist_q[i].stamp));
                end
            end
            check_that(in_window <= gpu_issue_pkg::NUM_SLOTS,
                       $sformatf("warp %0d has %0d writebacks in one window", w, in_window));
            e.stamp = cycle;
            hist_q.push_back(e);
        end
    endtask

    // Sample on the falling edge, inputs and outputs are settled there
    always @(negedge clk) begin
        cycle++;
        while (hist_q.size() > 0 && cycle - hist_q[0].stamp >= EXEC_LATENCY)
            hist_q.pop_front();                        // Slide the window
        if (rst) begin
            if (wb_valid)
                retire(wb_warp, wb_dst, wb_dst_valid);
            if (in_valid && in_ready)
                accept();
            run = wb_valid ? run + 1 : 0;              // Back-to-back writebacks
            if (run > max_run)
                max_run = run;
            if (burst_active && in_valid && in_warp == BURST_WARP) begin
                if (!in_ready)
                    ready_fell = 1'b1;
                else if (ready_fell)
                    ready_rose = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    function automatic instr_t random_instr();
        // Registers 0..3 only, so hazards are frequent
        return make_instr(gpu_issue_pkg::reg_id_t'($urandom_range(0, 3)),
                          $urandom_range(0, 3) != 0,
                          gpu_issue_pkg::reg_id_t'($urandom_range(0, 3)),
                          $urandom_range(0, 3) != 0,
                          gpu_issue_pkg::reg_id_t'($urandom_range(0, 3)),
                          $urandom_range(0, 3) != 0);
    endfunction

    task automatic send_instr(input gpu_issue_pkg::warp_id_t w, input instr_t ins);
        int waited;
        @(posedge clk);
        in_valid      <= 1'b1;
        in_warp       <= w;
        in_src1       <= ins.src1;
        in_src2       <= ins.src2;
        in_dst        <= ins.dst;
        in_src1_valid <= ins.src1_valid;
        in_src2_valid <= ins.src2_valid;
        in_dst_valid  <= ins.dst_valid;
        waited = 0;
        @(negedge clk);
        while (!(in_valid && in_ready) && waited < SEND_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!(in_valid && in_ready)) begin
            timed_out = 1'b1;
            $display("Timeout: warp %0d did not take an instruction in %0d cycles",
                     w, SEND_LIMIT);
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic drain_pipe(input string phase);
        int waited;
        waited = 0;
        idle_cycle();
        while (acc_q.size() > 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (acc_q.size() > 0) begin
            timed_out = 1'b1;
            $display("Timeout: %0d instructions of the %s phase never wrote back",
                     acc_q.size(), phase);
        end else begin
            repeat (EXEC_LATENCY) @(posedge clk);   // Nothing extra may come out
        end
    endtask

    initial begin
        void'($urandom(32'h79dd));                     // Single seed for the run
        rst           = 1'b0;
        in_valid      = 1'b0;
        in_warp       = '0;
        in_src1       = '0;
        in_src2       = '0;
        in_dst        = '0;
        in_src1_valid = 1'b0;
        in_src2_valid = 1'b0;
        in_dst_valid  = 1'b0;
        {cycle, run, max_run, checks, errors} = '0;
        {timed_out, burst_active, ready_fell, ready_rose} = '0;
        foreach (outstanding[w])
            outstanding[w] = 0;

        repeat (3) @(posedge clk);
        rst <= 1'b1;

        // Idle outputs and open input on every warp
        for (int w = 0; w < NUM_WARPS; w++) begin
            @(posedge clk);
            in_warp <= gpu_issue_pkg::warp_id_t'(w);
            @(negedge clk);
            check_that(!wb_valid && in_ready, $sformatf("warp %0d not idle after reset", w));
        end

        for (int n = 0; n < RAND_INSTRS && !timed_out; n++) begin
            send_instr(gpu_issue_pkg::warp_id_t'($urandom_range(0, NUM_WARPS - 1)),
                       random_instr());
            if ($urandom_range(0, 3) == 0)
                idle_cycle();
        end
        if (!timed_out)
            drain_pipe("random");

        // RAW and WAW chain on one warp fills its FIFO
        if (!timed_out) begin
            burst_active = 1'b1;
            for (int n = 0; n < 12 && !timed_out; n++)
                send_instr(BURST_WARP, make_instr(5'd2, 1'b1, 5'd0, 1'b0, 5'd2, 1'b1));
            if (!timed_out)
                drain_pipe("dependence chain");
            burst_active = 1'b0;
            check_that(ready_fell && ready_rose, "in_ready did not fall and rise in the burst");
        end

        // Independent burst on one warp runs into the four-slot limit
        if (!timed_out) begin
            for (int n = 0; n < 12 && !timed_out; n++)
                send_instr(BURST_WARP, make_instr(5'd0, 1'b0, 5'd0, 1'b0,
                                                  gpu_issue_pkg::reg_id_t'(n + 16), 1'b1));
            if (!timed_out)
                drain_pipe("slot limit");
        end

        // One independent instruction per warp, back to back
        if (!timed_out) begin
            max_run = 0;
            for (int w = 0; w < NUM_WARPS && !timed_out; w++)
                send_instr(gpu_issue_pkg::warp_id_t'(w),
                           make_instr(5'd0, 1'b0, 5'd0, 1'b0,
                                      gpu_issue_pkg::reg_id_t'(w + 8), 1'b1));
            if (!timed_out)
                drain_pipe("independent");
            check_that(max_run >= NUM_WARPS,
                       $sformatf("longest writeback run %0d cycles", max_run));
        end

        $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 100  // ns
) (
    output logic clk
);

    initial clk = 1'b0;

    // Half period high, half low
    always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== issue_top.sv ====
`timescale 1ns/1ns

module issue_top #(
    parameter int NUM_WARPS    = gpu_issue_pkg::NUM_WARPS,
    parameter int EXEC_LATENCY = gpu_issue_pkg::EXEC_LATENCY
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  gpu_issue_pkg::warp_id_t in_warp,
    input  gpu_issue_pkg::reg_id_t  in_src1,
    input  gpu_issue_pkg::reg_id_t  in_src2,
    input  gpu_issue_pkg::reg_id_t  in_dst,
    input  logic                    in_src1_valid,
    input  logic                    in_src2_valid,
    input  logic                    in_dst_valid,
    output logic                    wb_valid,        // No ready, always taken
    output gpu_issue_pkg::warp_id_t wb_warp,
    output gpu_issue_pkg::reg_id_t  wb_dst,
    output logic                    wb_dst_valid
);
    localparam int REG_W  = gpu_issue_pkg::REG_W;
    localparam int SLOT_W = gpu_issue_pkg::SLOT_W;

    logic [NUM_WARPS-1:0]        head_valid, head_src1_valid, head_src2_valid, head_dst_valid;
    logic [NUM_WARPS*REG_W-1:0]  head_src1, head_src2, head_dst;
    logic [NUM_WARPS-1:0]        slot_full, dependent, grant;
    logic [NUM_WARPS*SLOT_W-1:0] free_slot;
    gpu_issue_pkg::warp_id_t     grant_warp;
    gpu_issue_pkg::slot_id_t     wb_slot;         // Back to the scoreboard as clear

    instr_buffer #(.NUM_WARPS(NUM_WARPS)) instr_buffer_inst (
        .clk, .rst, .in_valid, .in_ready, .in_warp, .in_src1, .in_src2, .in_dst,
        .in_src1_valid, .in_src2_valid, .in_dst_valid,
        .pop (grant),                               // Pop on the grant edge
        .head_valid, .head_src1, .head_src2, .head_dst,
        .head_src1_valid, .head_src2_valid, .head_dst_valid
    );

    issue_unit #(.NUM_WARPS(NUM_WARPS)) issue_unit_inst (
        .clk, .rst, .head_valid, .slot_full, .dependent, .grant, .grant_warp
    );

    scoreboard #(.NUM_WARPS(NUM_WARPS)) scoreboard_inst (
        .clk, .rst, .head_src1, .head_src2, .head_dst,
        .head_src1_valid, .head_src2_valid, .head_dst_valid, .grant,
        .clr_valid (wb_valid),
        .clr_warp  (wb_warp),
        .clr_slot  (wb_slot),
        .slot_full, .dependent, .free_slot
    );

    // Granted warp's head and slot into stage 0
    exec_pipe #(.EXEC_LATENCY(EXEC_LATENCY)) exec_pipe_inst (
        .clk, .rst,
        .issue_valid     (|grant),
        .issue_warp      (grant_warp),
        .issue_slot      (free_slot[grant_warp*SLOT_W +: SLOT_W]),
        .issue_dst       (head_dst[grant_warp*REG_W +: REG_W]),
        .issue_dst_valid (head_dst_valid[grant_warp]),
        .wb_valid, .wb_warp, .wb_slot, .wb_dst, .wb_dst_valid
    );

endmodule

// ==== exec_pipe.sv ====
`timescale 1ns/1ns

module exec_pipe #(
    parameter int EXEC_LATENCY = gpu_issue_pkg::EXEC_LATENCY
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  gpu_issue_pkg::warp_id_t issue_warp,
    input  gpu_issue_pkg::slot_id_t issue_slot,
    input  gpu_issue_pkg::reg_id_t  issue_dst,
    input  logic                    issue_dst_valid,
    // Last stage, shared by writeback and the scoreboard clear
    output logic                    wb_valid,
    output gpu_issue_pkg::warp_id_t wb_warp,
    output gpu_issue_pkg::slot_id_t wb_slot,
    output gpu_issue_pkg::reg_id_t  wb_dst,
    output logic                    wb_dst_valid
);
    logic [EXEC_LATENCY-1:0] stg_valid;
    gpu_issue_pkg::warp_id_t stg_warp      [EXEC_LATENCY];
    gpu_issue_pkg::slot_id_t stg_slot      [EXEC_LATENCY];
    gpu_issue_pkg::reg_id_t  stg_dst       [EXEC_LATENCY];
    logic [EXEC_LATENCY-1:0] stg_dst_valid;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            stg_valid <= '0;  // Empty pipe
        else
            stg_valid <= {stg_valid[EXEC_LATENCY-2:0], issue_valid};
    end

    // Tags ride along, qualified by stg_valid
    always_ff @(posedge clk) begin
        stg_warp[0]      <= issue_warp;
        stg_slot[0]      <= issue_slot;
        stg_dst[0]       <= issue_dst;
        stg_dst_valid[0] <= issue_dst_valid;
        for (int k = 1; k < EXEC_LATENCY; k++) begin
            stg_warp[k]      <= stg_warp[k-1];
            stg_slot[k]      <= stg_slot[k-1];
            stg_dst[k]       <= stg_dst[k-1];
            stg_dst_valid[k] <= stg_dst_valid[k-1];
        end
    end

    assign wb_valid     = stg_valid[EXEC_LATENCY-1];
    assign wb_warp      = stg_warp[EXEC_LATENCY-1];
    assign wb_slot      = stg_slot[EXEC_LATENCY-1];
    assign wb_dst       = stg_dst[EXEC_LATENCY-1];
    assign wb_dst_valid = stg_dst_valid[EXEC_LATENCY-1];

endmodule

// ==== issue_unit.sv ====
`timescale 1ns/1ns

module issue_unit #(
    parameter int NUM_WARPS = gpu_issue_pkg::NUM_WARPS
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [NUM_WARPS-1:0]    head_valid,
    input  logic [NUM_WARPS-1:0]    slot_full,
    input  logic [NUM_WARPS-1:0]    dependent,
    output logic [NUM_WARPS-1:0]    grant,       // One-hot or zero
    output gpu_issue_pkg::warp_id_t grant_warp
);
    logic [NUM_WARPS-1:0]    eligible;
    gpu_issue_pkg::warp_id_t last;               // Last granted warp

    // Head present, slot free, no hazard
    assign eligible = head_valid & ~slot_full & ~dependent;

    ////////////////////////////////////////////////////////////////////////////
    // Round-robin pick, starting after the last grant
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        int   idx;
        logic found;

        found      = 1'b0;
        grant      = '0;
        grant_warp = '0;
        for (int k = 1; k <= NUM_WARPS; k++) begin
            idx = (int'(last) + k) % NUM_WARPS;
            if (!found && eligible[idx]) begin
                found      = 1'b1;
                grant[idx] = 1'b1;
                grant_warp = gpu_issue_pkg::warp_id_t'(idx);
            end
        end
    end

    // Pointer moves on a grant only
    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            last <= gpu_issue_pkg::warp_id_t'(NUM_WARPS - 1);  // Warp 0 first
        else if (|grant)
            last <= grant_warp;
    end

endmodule

// ==== scoreboard.sv ====
`timescale 1ns/1ns

module scoreboard #(
    parameter int NUM_WARPS = gpu_issue_pkg::NUM_WARPS
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [NUM_WARPS*gpu_issue_pkg::REG_W-1:0]  head_src1,
    input  logic [NUM_WARPS*gpu_issue_pkg::REG_W-1:0]  head_src2,
    input  logic [NUM_WARPS*gpu_issue_pkg::REG_W-1:0]  head_dst,
    input  logic [NUM_WARPS-1:0]                       head_src1_valid,
    input  logic [NUM_WARPS-1:0]                       head_src2_valid,
    input  logic [NUM_WARPS-1:0]                       head_dst_valid,
    input  logic [NUM_WARPS-1:0]                       grant,
    input  logic                                       clr_valid,   // From pipe last stage
    input  gpu_issue_pkg::warp_id_t                    clr_warp,
    input  gpu_issue_pkg::slot_id_t                    clr_slot,
    output logic [NUM_WARPS-1:0]                       slot_full,
    output logic [NUM_WARPS-1:0]                       dependent,
    output logic [NUM_WARPS*gpu_issue_pkg::SLOT_W-1:0] free_slot
);
    localparam int REG_W  = gpu_issue_pkg::REG_W;
    localparam int SLOT_W = gpu_issue_pkg::SLOT_W;

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_warp
        logic clr_hit;

        assign clr_hit = clr_valid && (clr_warp == gpu_issue_pkg::warp_id_t'(w));  // Owner only

        scoreboard_warp scoreboard_warp_inst (
            .clk        (clk),
            .rst        (rst),
            .src1       (head_src1[w*REG_W +: REG_W]),
            .src2       (head_src2[w*REG_W +: REG_W]),
            .dst        (head_dst[w*REG_W +: REG_W]),
            .src1_valid (head_src1_valid[w]),
            .src2_valid (head_src2_valid[w]),
            .dst_valid  (head_dst_valid[w]),
            .issue      (grant[w]),
            .clr_valid  (clr_hit),
            .clr_slot   (clr_slot),
            .full       (slot_full[w]),
            .dependent  (dependent[w]),
            .free_slot  (free_slot[w*SLOT_W +: SLOT_W])
        );
    end

endmodule

// ==== scoreboard_warp.sv ====
`timescale 1ns/1ns

module scoreboard_warp (
    input  logic                     clk,
    input  logic                     rst,
    // Head instruction of this warp
    input  gpu_issue_pkg::reg_id_t   src1,
    input  gpu_issue_pkg::reg_id_t   src2,
    input  gpu_issue_pkg::reg_id_t   dst,
    input  logic                     src1_valid,
    input  logic                     src2_valid,
    input  logic                     dst_valid,
    input  logic                     issue,      // Head granted this cycle
    // Writeback clear for this warp
    input  logic                     clr_valid,
    input  gpu_issue_pkg::slot_id_t  clr_slot,
    output logic                     full,
    output logic                     dependent,
    output gpu_issue_pkg::slot_id_t  free_slot
);
    localparam int NUM_SLOTS = gpu_issue_pkg::NUM_SLOTS;

    ////////////////////////////////////////////////////////////////////////////
    // Slot table
    ////////////////////////////////////////////////////////////////////////////
    gpu_issue_pkg::reg_id_t slot_src1 [NUM_SLOTS];
    gpu_issue_pkg::reg_id_t slot_src2 [NUM_SLOTS];
    gpu_issue_pkg::reg_id_t slot_dst  [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]   slot_src1_valid;
    logic [NUM_SLOTS-1:0]   slot_src2_valid;
    logic [NUM_SLOTS-1:0]   slot_dst_valid;
    logic [NUM_SLOTS-1:0]   busy;
    logic [NUM_SLOTS-1:0]   busy_clr;        // Busy with the same-cycle clear applied
    logic [NUM_SLOTS-1:0]   dep_vec;

    always_comb begin
        busy_clr = busy;
        if (clr_valid)
            busy_clr[clr_slot] = 1'b0;
    end

    assign full = &busy_clr;

    // Lowest free slot, scanned from the top
    always_comb begin
        free_slot = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (!busy_clr[i])
                free_slot = gpu_issue_pkg::slot_id_t'(i);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy <= '0;
        end else begin
            busy <= busy_clr;
            if (issue)
                busy[free_slot] <= 1'b1;  // Issue only when not full
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            slot_src1[free_slot]       <= src1;
            slot_src2[free_slot]       <= src2;
            slot_dst[free_slot]        <= dst;
            slot_src1_valid[free_slot] <= src1_valid;
            slot_src2_valid[free_slot] <= src2_valid;
            slot_dst_valid[free_slot]  <= dst_valid;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Hazard check against pending slots
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            dep_vec[i] = busy_clr[i] && (
                // RAW, head reads a pending destination
                (src1_valid && slot_dst_valid[i] && (src1 == slot_dst[i])) ||
                (src2_valid && slot_dst_valid[i] && (src2 == slot_dst[i])) ||
                // WAW
                (dst_valid && slot_dst_valid[i] && (dst == slot_dst[i])) ||
                // WAR, head overwrites a pending source
                (dst_valid && slot_src1_valid[i] && (dst == slot_src1[i])) ||
                (dst_valid && slot_src2_valid[i] && (dst == slot_src2[i])));
        end
    end

    assign dependent = |dep_vec;

endmodule

// ==== instr_buffer.sv ====
`timescale 1ns/1ns

module instr_buffer #(
    parameter int NUM_WARPS = gpu_issue_pkg::NUM_WARPS
) (
    input  logic                                      clk,
    input  logic                                      rst,
    // Incoming tagged instruction
    input  logic                                      in_valid,
    output logic                                      in_ready,
    input  gpu_issue_pkg::warp_id_t                   in_warp,
    input  gpu_issue_pkg::reg_id_t                    in_src1,
    input  gpu_issue_pkg::reg_id_t                    in_src2,
    input  gpu_issue_pkg::reg_id_t                    in_dst,
    input  logic                                      in_src1_valid,
    input  logic                                      in_src2_valid,
    input  logic                                      in_dst_valid,
    // One pop strobe per warp, from the grant
    input  logic [NUM_WARPS-1:0]                      pop,
    // Head of every warp, flattened
    output logic [NUM_WARPS-1:0]                      head_valid,
    output logic [NUM_WARPS*gpu_issue_pkg::REG_W-1:0] head_src1,
    output logic [NUM_WARPS*gpu_issue_pkg::REG_W-1:0] head_src2,
    output logic [NUM_WARPS*gpu_issue_pkg::REG_W-1:0] head_dst,
    output logic [NUM_WARPS-1:0]                      head_src1_valid,
    output logic [NUM_WARPS-1:0]                      head_src2_valid,
    output logic [NUM_WARPS-1:0]                      head_dst_valid
);
    typedef enum logic [1:0] {EMPTY, ONE, FULL} ib_state_t;

    localparam int REG_W = gpu_issue_pkg::REG_W;
    localparam int ENT_W = 3 * REG_W + 3;  // Three ids plus three valids

    logic [ENT_W-1:0]     in_ent;
    logic [NUM_WARPS-1:0] warp_full;

    assign in_ent = {in_src1, in_src2, in_dst, in_src1_valid, in_src2_valid, in_dst_valid};
    assign in_ready = !warp_full[in_warp];  // Only the addressed warp matters

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_warp
        ib_state_t        state;
        logic [ENT_W-1:0] ent [gpu_issue_pkg::IB_DEPTH];  // ent[0] is the head
        logic             push;

        assign push = in_valid && in_ready && (in_warp == gpu_issue_pkg::warp_id_t'(w));
        assign warp_full[w] = (state == FULL);
        assign head_valid[w] = (state != EMPTY);
        assign {head_src1[w*REG_W +: REG_W], head_src2[w*REG_W +: REG_W],
                head_dst[w*REG_W +: REG_W], head_src1_valid[w],
                head_src2_valid[w], head_dst_valid[w]} = ent[0];

        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                state <= EMPTY;
            end else begin
                case (state)
                    EMPTY:   if (push) state <= ONE;
                    ONE: begin
                        if (push && !pop[w])
                            state <= FULL;
                        else if (!push && pop[w])
                            state <= EMPTY;  // Push plus pop stays at ONE
                    end
                    FULL:    if (pop[w]) state <= ONE;  // No push while full
                    default: state <= EMPTY;
                endcase
            end
        end

        // Payload moves, order kept on simultaneous push and pop
        always_ff @(posedge clk) begin
            case (state)
                EMPTY:   if (push) ent[0] <= in_ent;
                ONE: begin
                    if (push && pop[w])
                        ent[0] <= in_ent;    // Replace the leaving head
                    else if (push)
                        ent[1] <= in_ent;    // Queue behind head
                end
                FULL:    if (pop[w]) ent[0] <= ent[1];  // Promote second entry
                default: ;
            endcase
        end
    end

endmodule

// ==== gpu_issue_pkg.sv ====
package gpu_issue_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Field widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int REG_W  = 5;             // Architectural register id
    localparam int WARP_W = 3;             // Up to 8 warps
    localparam int SLOT_W = 2;             // Scoreboard slot index

    localparam int NUM_SLOTS = 2 ** SLOT_W; // Four pending instrs per warp

    typedef logic [REG_W-1:0]  reg_id_t;
    typedef logic [WARP_W-1:0] warp_id_t;
    typedef logic [SLOT_W-1:0] slot_id_t;

    ////////////////////////////////////////////////////////////////////////////
    // Default sizing, overridden from the top level
    ////////////////////////////////////////////////////////////////////////////
    localparam int NUM_WARPS    = 8;
    localparam int IB_DEPTH     = 2;       // Skid pair per warp
    localparam int EXEC_LATENCY = 6;       // Tag pipe stages

endpackage
